/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tracker_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/dot_writer.sv */
`timescale 1ns/10ps

module dot_writer #(
    parameter int h_active = 640,
    parameter int v_active = 480
) (
    input  logic                vga_clk,
    input  logic                rst,
    input  logic                grant,
    input  logic                ready,
    input  tracker_pkg::word_t  rdata,
    input  logic [9:0]          cam_x,
    input  logic [9:0]          cam_y,
    input  logic                cam_valid,
    input  logic                erase,
    output tracker_pkg::addr_t  addr,
    output logic                read,
    output logic                write,
    output tracker_pkg::word_t  wdata
);

    localparam int words_per_line = h_active / tracker_pkg::px_per_word;
    localparam int frame_words    = words_per_line * v_active;

    tracker_pkg::dot_state_t state;
    logic [3:0]              bit_sel;
    logic                    in_frame;
    logic                    start;
    logic                    last_word;

    assign in_frame  = (cam_x < 10'(h_active)) && (cam_y < 10'(v_active));
    // wait_grant is only entered with grant low, so this is its rising edge
    assign start     = (state == tracker_pkg::wait_grant) && grant;
    assign last_word = (addr == tracker_pkg::addr_t'(frame_words - 1));

    assign read  = ready && (state == tracker_pkg::read_req);
    assign write = ready && (state == tracker_pkg::write_req
                             || state == tracker_pkg::erase_req);

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            state <= tracker_pkg::wait_grant;
        end else begin
            case (state)
                tracker_pkg::wait_grant:
                    if (grant) begin
                        if (erase)
                            state <= tracker_pkg::erase_req;
                        else if (cam_valid && in_frame)
                            state <= tracker_pkg::read_req;
                        else
                            state <= tracker_pkg::done;
                    end
                tracker_pkg::read_req:
                    if (ready) state <= tracker_pkg::read_wait;
                tracker_pkg::read_wait:
                    if (ready) state <= tracker_pkg::write_req;
                tracker_pkg::write_req:
                    if (ready) state <= tracker_pkg::write_wait;
                tracker_pkg::write_wait:
                    if (ready) state <= tracker_pkg::done;
                tracker_pkg::erase_req:
                    if (ready) state <= tracker_pkg::erase_wait;
                tracker_pkg::erase_wait:
                    if (ready) state <= last_word ? tracker_pkg::done : tracker_pkg::erase_req;
                tracker_pkg::done:
                    if (!grant) state <= tracker_pkg::wait_grant;
                default:
                    state <= tracker_pkg::wait_grant;
            endcase
        end
    end

    always_ff @(posedge vga_clk) begin
        if (start) begin
            bit_sel <= cam_x[3:0];
            wdata   <= '0;
            if (erase)
                addr <= '0;
            else
                addr <= tracker_pkg::addr_t'(int'(cam_y) * words_per_line
                                             + int'(cam_x[9:4]));
        end
        // merge the dot into the word just read
        if (state == tracker_pkg::read_wait && ready)
            wdata <= rdata | (tracker_pkg::word_t'(1) << bit_sel);
        if (state == tracker_pkg::erase_wait && ready)
            addr <= addr + 1'b1;
    end

endmodule

/* hw/scan_reader.sv */
`timescale 1ns/10ps

module scan_reader #(
    parameter int h_active = 640,
    parameter int h_total  = 800,
    parameter int v_active = 480
) (
    input  logic                vga_clk,
    input  logic                rst,
    input  logic [10:0]         hcount,
    input  logic [9:0]          vcount,
    input  logic                ready,
    input  tracker_pkg::word_t  rdata,
    output tracker_pkg::addr_t  addr,
    output logic                read,
    output logic                pixel
);

    localparam int words_per_line = h_active / tracker_pkg::px_per_word;
    // line start fetch is issued this many clocks before the line begins
    localparam int lead = 8;

    logic               visible;
    logic               group_fetch;
    logic               line_fetch;
    logic               need;
    logic               inflight;
    tracker_pkg::word_t fetched;
    tracker_pkg::word_t shifter;

    assign visible = (hcount < 11'(h_active)) && (vcount < 10'(v_active));

    // next group's word, asked for early in the current group
    assign group_fetch = visible && hcount[3:0] == 4'd1
                         && hcount < 11'(h_active - tracker_pkg::px_per_word);

    // first word of the coming line; in vertical blanking this is line 0 and
    // stays pending until the SRAM comes back to us
    assign line_fetch = hcount == 11'(h_total - lead)
                        && vcount != 10'(v_active - 1);

    assign read = need && ready;

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            need     <= 1'b0;
            inflight <= 1'b0;
            fetched  <= '0;
        end else begin
            if (group_fetch) begin
                need <= 1'b1;
                addr <= tracker_pkg::addr_t'(int'(vcount) * words_per_line
                                             + int'(hcount[10:4]) + 1);
            end else if (line_fetch) begin
                need <= 1'b1;
                if (vcount < 10'(v_active - 1))
                    addr <= tracker_pkg::addr_t'((int'(vcount) + 1) * words_per_line);
                else
                    addr <= '0;
            end else if (read) begin
                need <= 1'b0;
            end
            // ready rises again with the word on rdata
            if (inflight && ready)
                fetched <= rdata;
            inflight <= read || (inflight && !ready);
        end
    end

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            pixel <= 1'b0;
        end else if (visible) begin
            if (hcount[3:0] == 4'd0) begin
                pixel   <= fetched[0];
                shifter <= fetched >> 1;
            end else begin
                pixel   <= shifter[0];
                shifter <= shifter >> 1;
            end
        end else begin
            pixel <= 1'b0;
        end
    end

endmodule

/* hw/sram_arbiter.sv */
`timescale 1ns/10ps

module sram_arbiter #(
    parameter int v_active = 480,
    parameter int v_total  = 525
) (
    input  logic                vga_clk,
    input  logic                rst,
    input  logic [9:0]          vcount,
    input  tracker_pkg::addr_t  sr_addr,
    input  logic                sr_read,
    input  tracker_pkg::addr_t  dw_addr,
    input  logic                dw_read,
    input  logic                dw_write,
    input  tracker_pkg::word_t  dw_wdata,
    input  logic                mem_ready,
    output logic                sr_ready,
    output logic                dw_ready,
    output logic                grant_dw,
    output tracker_pkg::addr_t  mem_addr,
    output logic                mem_read,
    output logic                mem_write,
    output tracker_pkg::word_t  mem_wdata
);

    logic want_dw;
    logic own_dw;
    logic mem_idle;
    logic settled;

    // dot writer gets vertical blanking except the last line, which the
    // scan reader needs to fetch the first word of line 0
    assign want_dw  = (vcount >= 10'(v_active)) && (vcount < 10'(v_total - 1));
    assign mem_idle = mem_ready && !mem_read && !mem_write;
    // nobody gets ready while a handover is pending
    assign settled  = (want_dw == own_dw);
    assign sr_ready = mem_idle && settled && !own_dw;
    assign dw_ready = mem_idle && settled && own_dw;
    assign grant_dw = own_dw;

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            own_dw    <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            mem_read  <= own_dw ? (dw_read && dw_ready) : (sr_read && sr_ready);
            mem_write <= dw_write && dw_ready;
            if (mem_idle && !settled)
                own_dw <= want_dw;
        end
    end

    always_ff @(posedge vga_clk) begin
        mem_addr  <= own_dw ? dw_addr : sr_addr;
        mem_wdata <= dw_wdata;
    end

endmodule

/* hw/sram_ctrl.sv */
`timescale 1ns/10ps

module sram_ctrl (
    input  logic                vga_clk,
    input  logic                rst,
    input  tracker_pkg::addr_t  addr,
    input  logic                read,
    input  logic                write,
    input  tracker_pkg::word_t  wdata,
    input  tracker_pkg::word_t  data_in,
    output logic                ready,
    output tracker_pkg::word_t  rdata,
    output tracker_pkg::addr_t  sram_addr,
    output tracker_pkg::word_t  data_out,
    output logic                data_oe,
    output logic                cs_n,
    output logic                oe_n,
    output logic                we_n
);

    tracker_pkg::sram_state_t state;
    logic                     accept;

    assign accept = (state == tracker_pkg::idle) && (read || write);

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            state   <= tracker_pkg::idle;
            ready   <= 1'b1;
            cs_n    <= 1'b1;
            oe_n    <= 1'b1;
            we_n    <= 1'b1;
            data_oe <= 1'b0;
        end else begin
            case (state)
                tracker_pkg::idle:
                    if (accept) begin
                        cs_n    <= 1'b0;
                        oe_n    <= !read;
                        we_n    <= !write;
                        data_oe <= write;
                        ready   <= 1'b0;
                        state   <= tracker_pkg::access;
                    end
                tracker_pkg::access: begin
                    // strobes end here, data bus held one clock longer
                    cs_n  <= 1'b1;
                    oe_n  <= 1'b1;
                    we_n  <= 1'b1;
                    ready <= 1'b1;
                    state <= tracker_pkg::finish;
                end
                tracker_pkg::finish: begin
                    data_oe <= 1'b0;
                    state   <= tracker_pkg::idle;
                end
                default:
                    state <= tracker_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge vga_clk) begin
        if (accept) begin
            sram_addr <= addr;
            data_out  <= wdata;
        end
        // valid on rdata during finish, when ready is back up
        if (state == tracker_pkg::access && !oe_n)
            rdata <= data_in;
    end

endmodule

/* hw/tracker_pkg.sv */
package tracker_pkg;

    // external SRAM geometry
    localparam int addr_w = 18;
    localparam int data_w = 16;

    // one bit per pixel, so a word covers this many pixels of a line
    localparam int px_per_word = data_w;

    typedef logic [addr_w-1:0] addr_t;

    // bit n is the pixel at x offset n within its group
    typedef logic [data_w-1:0] word_t;

    typedef enum logic [1:0] {
        idle,
        access,
        finish
    } sram_state_t;

    typedef enum logic [2:0] {
        wait_grant,
        read_req,
        read_wait,
        write_req,
        write_wait,
        erase_req,
        erase_wait,
        done
    } dot_state_t;

endpackage

/* hw/tracker_top.sv */
`timescale 1ns/10ps

module tracker_top #(
    parameter int h_active = 640,
    parameter int h_total  = 800,
    parameter int v_active = 480,
    parameter int v_total  = 525
) (
    input  logic                vga_clk,
    input  logic                rst,
    input  logic [9:0]          cam_x,
    input  logic [9:0]          cam_y,
    input  logic                cam_valid,
    input  logic                erase,
    input  tracker_pkg::word_t  data_in,
    output logic                hsync,
    output logic                vsync,
    output logic                blank,
    output logic                pixel,
    output tracker_pkg::addr_t  sram_addr,
    output tracker_pkg::word_t  data_out,
    output logic                data_oe,
    output logic                cs_n,
    output logic                oe_n,
    output logic                we_n
);

    logic [10:0]        hcount;
    logic [9:0]         vcount;

    // requester side
    tracker_pkg::addr_t sr_addr;
    logic               sr_read;
    logic               sr_ready;
    tracker_pkg::addr_t dw_addr;
    logic               dw_read;
    logic               dw_write;
    tracker_pkg::word_t dw_wdata;
    logic               dw_ready;
    logic               grant_dw;

    // arbiter to controller
    tracker_pkg::addr_t mem_addr;
    logic               mem_read;
    logic               mem_write;
    tracker_pkg::word_t mem_wdata;
    logic               mem_ready;
    tracker_pkg::word_t mem_rdata;

    video_timing #(
        .h_active(h_active),
        .h_total (h_total),
        .v_active(v_active),
        .v_total (v_total)
    ) u_timing (
        .vga_clk(vga_clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .blank  (blank)
    );

    scan_reader #(
        .h_active(h_active),
        .h_total (h_total),
        .v_active(v_active)
    ) u_scan (
        .vga_clk(vga_clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .ready  (sr_ready),
        .rdata  (mem_rdata),
        .addr   (sr_addr),
        .read   (sr_read),
        .pixel  (pixel)
    );

    dot_writer #(
        .h_active(h_active),
        .v_active(v_active)
    ) u_dots (
        .vga_clk  (vga_clk),
        .rst      (rst),
        .grant    (grant_dw),
        .ready    (dw_ready),
        .rdata    (mem_rdata),
        .cam_x    (cam_x),
        .cam_y    (cam_y),
        .cam_valid(cam_valid),
        .erase    (erase),
        .addr     (dw_addr),
        .read     (dw_read),
        .write    (dw_write),
        .wdata    (dw_wdata)
    );

    sram_arbiter #(
        .v_active(v_active),
        .v_total (v_total)
    ) u_arb (
        .vga_clk  (vga_clk),
        .rst      (rst),
        .vcount   (vcount),
        .sr_addr  (sr_addr),
        .sr_read  (sr_read),
        .dw_addr  (dw_addr),
        .dw_read  (dw_read),
        .dw_write (dw_write),
        .dw_wdata (dw_wdata),
        .mem_ready(mem_ready),
        .sr_ready (sr_ready),
        .dw_ready (dw_ready),
        .grant_dw (grant_dw),
        .mem_addr (mem_addr),
        .mem_read (mem_read),
        .mem_write(mem_write),
        .mem_wdata(mem_wdata)
    );

    sram_ctrl u_sram (
        .vga_clk  (vga_clk),
        .rst      (rst),
        .addr     (mem_addr),
        .read     (mem_read),
        .write    (mem_write),
        .wdata    (mem_wdata),
        .data_in  (data_in),
        .ready    (mem_ready),
        .rdata    (mem_rdata),
        .sram_addr(sram_addr),
        .data_out (data_out),
        .data_oe  (data_oe),
        .cs_n     (cs_n),
        .oe_n     (oe_n),
        .we_n     (we_n)
    );

endmodule

/* hw/video_timing.sv */
`timescale 1ns/10ps

module video_timing #(
    parameter int h_active = 640,
    parameter int h_total  = 800,
    parameter int v_active = 480,
    parameter int v_total  = 525
) (
    input  logic        vga_clk,
    input  logic        rst,
    output logic [10:0] hcount,
    output logic [9:0]  vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        blank
);

    // sync starts a quarter into each blanking interval and lasts half of it
    localparam int h_blank  = h_total - h_active;
    localparam int v_blank  = v_total - v_active;
    localparam int hs_start = h_active + h_blank / 4;
    localparam int hs_end   = hs_start + h_blank / 2;
    localparam int vs_start = v_active + v_blank / 4;
    localparam int vs_end   = vs_start + v_blank / 2;

    logic line_end;

    assign line_end = (hcount == 11'(h_total - 1));

    always_ff @(posedge vga_clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            if (vcount == 10'(v_total - 1))
                vcount <= '0;
            else
                vcount <= vcount + 10'd1;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // registered, so these lag the counters by one clock
    always_ff @(posedge vga_clk) begin
        if (rst) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            blank <= 1'b0;
        end else begin
            hsync <= !(hcount >= 11'(hs_start) && hcount < 11'(hs_end));
            vsync <= !(vcount >= 10'(vs_start) && vcount < 10'(vs_end));
            blank <= (hcount >= 11'(h_active)) || (vcount >= 10'(v_active));
        end
    end

endmodule

/* list.f */
hw/tracker_pkg.sv
hw/video_timing.sv
hw/scan_reader.sv
hw/dot_writer.sv
hw/sram_arbiter.sv
hw/sram_ctrl.sv
hw/tracker_top.sv
sim/tracker_asserts.sv
sim/tracker_tb.sv

/* sim/tracker_asserts.sv */
`timescale 1ns/10ps

module sram_pin_checks (
    input logic vga_clk,
    input logic rst,
    input logic read,
    input logic write,
    input logic ready,
    input logic data_oe,
    input logic cs_n,
    input logic oe_n,
    input logic we_n
);

    int fails = 0;

    // pins parked while in reset
    reset_idle: assert property (@(posedge vga_clk)
        rst |=> (cs_n && oe_n && we_n && !data_oe))
        else begin
            $error("SRAM strobes or data_oe active after reset");
            fails++;
        end

    // low for one cycle after the accept, high in the second
    accept_to_ready: assert property (@(posedge vga_clk) disable iff (rst)
        $past(ready && (read || write), 2) |-> (ready && !$past(ready)))
        else begin
            $error("ready not back exactly two cycles after an accepted request");
            fails++;
        end

    no_we_with_oe: assert property (@(posedge vga_clk) disable iff (rst)
        !(!we_n && !oe_n))
        else begin
            $error("we_n and oe_n low together");
            fails++;
        end

endmodule

bind sram_ctrl sram_pin_checks u_pin_checks (
    .vga_clk(vga_clk),
    .rst    (rst),
    .read   (read),
    .write  (write),
    .ready  (ready),
    .data_oe(data_oe),
    .cs_n   (cs_n),
    .oe_n   (oe_n),
    .we_n   (we_n)
);

/* sim/tracker_tb.sv */
`timescale 1ns/10ps

module tracker_tb;

    // small frame so a full image is checked in a few hundred clocks
    localparam int h_active   = 16;
    localparam int h_total    = 32;
    localparam int v_active   = 8;
    localparam int v_total    = 12;
    localparam int clk_period = 8;
    localparam int sram_words = 256;
    localparam int n_rows     = 19;
    localparam int n_fixed    = 9;
    localparam int watchdog_ns = (n_rows + 1) * v_total * h_total * clk_period * 2;
    // 16 pixels per word, row-major
    localparam int frame_words = h_active / 16 * v_active;

    logic               vga_clk;
    logic               rst;
    logic [9:0]         cam_x;
    logic [9:0]         cam_y;
    logic               cam_valid;
    logic               erase;
    tracker_pkg::word_t data_in;
    logic               hsync;
    logic               vsync;
    logic               blank;
    logic               pixel;
    tracker_pkg::addr_t sram_addr;
    tracker_pkg::word_t data_out;
    logic               data_oe;
    logic               cs_n;
    logic               oe_n;
    logic               we_n;

    // external SRAM model
    tracker_pkg::word_t sram [sram_words];

    // frame table, one row per frame
    int    row_x     [n_rows];
    int    row_y     [n_rows];
    logic  row_valid [n_rows];
    logic  row_erase [n_rows];
    string row_desc  [n_rows];

    // expected image, indexed [y][x]
    logic shadow [v_active][h_active];

    int   cnt_h;
    int   cnt_v;
    int   out_h;
    int   out_v;
    logic out_ok;
    int   checks;
    int   pixel_errors;
    int   blank_errors;
    int   sync_errors;
    int   write_errors;

    tracker_top #(
        .h_active(h_active),
        .h_total (h_total),
        .v_active(v_active),
        .v_total (v_total)
    ) dut (
        .vga_clk  (vga_clk),
        .rst      (rst),
        .cam_x    (cam_x),
        .cam_y    (cam_y),
        .cam_valid(cam_valid),
        .erase    (erase),
        .data_in  (data_in),
        .hsync    (hsync),
        .vsync    (vsync),
        .blank    (blank),
        .pixel    (pixel),
        .sram_addr(sram_addr),
        .data_out (data_out),
        .data_oe  (data_oe),
        .cs_n     (cs_n),
        .oe_n     (oe_n),
        .we_n     (we_n)
    );

    initial begin
        vga_clk = 1'b0;
        forever #(clk_period / 2) vga_clk = ~vga_clk;
    end

    assign data_in = sram[sram_addr[7:0]];

    always @(posedge vga_clk) begin
        if (!cs_n && !we_n) begin
            // only words of the visible frame may ever be written
            assert (sram_addr < frame_words) else begin
                write_errors++;
                $display("FAIL %0t: SRAM write to word %0d outside the frame buffer",
                         $time, sram_addr);
            end
            sram[sram_addr[7:0]] <= data_out;
        end
    end

    // line and frame position, and the pixel shown one clock later
    always @(posedge vga_clk) begin
        if (rst) begin
            cnt_h  <= 0;
            cnt_v  <= 0;
            out_ok <= 1'b0;
        end else begin
            out_h  <= cnt_h;
            out_v  <= cnt_v;
            out_ok <= 1'b1;
            if (cnt_h == h_total - 1) begin
                cnt_h <= 0;
                cnt_v <= (cnt_v == v_total - 1) ? 0 : cnt_v + 1;
            end else begin
                cnt_h <= cnt_h + 1;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic set_row(input int i, input int x, input int y,
                           input logic valid, input logic clear, input string desc);
        row_x[i]     = x;
        row_y[i]     = y;
        row_valid[i] = valid;
        row_erase[i] = clear;
        row_desc[i]  = desc;
    endtask

    task automatic build_table();
        logic [31:0] seed;
        int          x;
        int          y;
        set_row(0, 0, 0, 1'b0, 1'b0, "no dot, empty image");
        set_row(1, 3, 2, 1'b1, 1'b0, "single dot at (3,2)");
        set_row(2, 7, 2, 1'b1, 1'b0, "second dot in the same word");
        set_row(3, 15, 2, 1'b1, 1'b0, "top bit of the same word");
        set_row(4, 5, 5, 1'b0, 1'b0, "cam_valid low");
        set_row(5, 20, 3, 1'b1, 1'b0, "x outside the frame");
        set_row(6, 4, 9, 1'b1, 1'b0, "y outside the frame");
        set_row(7, 1, 1, 1'b1, 1'b1, "erase held");
        set_row(8, 9, 6, 1'b1, 1'b0, "lone dot after erase");
        seed = 32'd26877;
        for (int i = n_fixed; i < n_rows; i++) begin
            seed = xorshift32(seed);
            x = int'(seed % h_active);
            y = int'((seed >> 8) % v_active);
            set_row(i, x, y, 1'b1, 1'b0, $sformatf("random dot at (%0d,%0d)", x, y));
        end
    endtask

    // compares one whole frame of blank, sync and pixel outputs
    task automatic check_frame();
        logic expect_blank;
        logic expect_px;
        logic prev_hs;
        logic prev_vs;
        int   hs_pulses;
        int   vs_pulses;
        prev_hs   = 1'b1;
        prev_vs   = 1'b1;
        hs_pulses = 0;
        vs_pulses = 0;
        for (int n = 0; n < h_total * v_total; n++) begin
            @(negedge vga_clk);
            if (out_ok) begin
                expect_blank = (out_h >= h_active) || (out_v >= v_active);
                checks++;
                assert (blank === expect_blank) else begin
                    blank_errors++;
                    $display("FAIL %0t: blank is %b at (%0d,%0d), expected %b",
                             $time, blank, out_h, out_v, expect_blank);
                end
                // sync pulses sit inside the blanking intervals
                checks++;
                assert (hsync === 1'b1 || out_h >= h_active) else begin
                    sync_errors++;
                    $display("FAIL %0t: hsync is %b at (%0d,%0d), expected 1",
                             $time, hsync, out_h, out_v);
                end
                checks++;
                assert (vsync === 1'b1 || out_v >= v_active) else begin
                    sync_errors++;
                    $display("FAIL %0t: vsync is %b at (%0d,%0d), expected 1",
                             $time, vsync, out_h, out_v);
                end
                if (prev_hs === 1'b1 && hsync === 1'b0)
                    hs_pulses++;
                if (prev_vs === 1'b1 && vsync === 1'b0)
                    vs_pulses++;
                prev_hs = hsync;
                prev_vs = vsync;
                if (!expect_blank) begin
                    expect_px = shadow[out_v][out_h];
                    checks++;
                    assert (pixel === expect_px) else begin
                        pixel_errors++;
                        $display("FAIL %0t: pixel at (%0d,%0d) is %b, expected %b",
                                 $time, out_h, out_v, pixel, expect_px);
                    end
                end
            end
        end
        // one hsync per line, one vsync per frame
        checks++;
        assert (hs_pulses == v_total && vs_pulses == 1) else begin
            sync_errors++;
            $display("FAIL %0t: %0d hsync and %0d vsync pulses in a frame, expected %0d and 1",
                     $time, hs_pulses, vs_pulses, v_total);
        end
    endtask

    task automatic update_shadow(input int r);
        if (row_erase[r]) begin
            for (int y = 0; y < v_active; y++)
                for (int x = 0; x < h_active; x++)
                    shadow[y][x] = 1'b0;
        end else if (row_valid[r] && row_x[r] < h_active && row_y[r] < v_active) begin
            shadow[row_y[r]][row_x[r]] = 1'b1;
        end
    endtask

    initial begin
        int r;
        int assert_fails;
        rst          = 1'b1;
        cam_x        = '0;
        cam_y        = '0;
        cam_valid    = 1'b0;
        erase        = 1'b0;
        checks       = 0;
        pixel_errors = 0;
        blank_errors = 0;
        sync_errors  = 0;
        write_errors = 0;
        for (int i = 0; i < sram_words; i++)
            sram[i] = '0;
        for (int y = 0; y < v_active; y++)
            for (int x = 0; x < h_active; x++)
                shadow[y][x] = 1'b0;
        build_table();
        repeat (2) @(posedge vga_clk);
        #1;
        rst = 1'b0;
        // each pass starts on the first clock of a frame
        for (r = 0; r <= n_rows; r++) begin
            if (r < n_rows) begin
                $display("frame %0d: %s", r, row_desc[r]);
                cam_x     = 10'(row_x[r]);
                cam_y     = 10'(row_y[r]);
                cam_valid = row_valid[r];
                erase     = row_erase[r];
            end else begin
                cam_valid = 1'b0;
                erase     = 1'b0;
            end
            check_frame();
            if (r < n_rows)
                update_shadow(r);
            @(posedge vga_clk);
            #1;
        end
        assert_fails = dut.u_sram.u_pin_checks.fails;
        $display("%0d checks, %0d pixel, %0d blank, %0d sync, %0d write errors, %0d assertion failures",
                 checks, pixel_errors, blank_errors, sync_errors, write_errors, assert_fails);
        if (pixel_errors + blank_errors + sync_errors + write_errors + assert_fails == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog: frames not finished after %0d ns", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
